// File: dcache_lce.f
+incdir+common
common/lce_pkg.sv
src/lce_credits.sv
dcache_lce/lce_req.sv
dcache_lce/lce_cmd.sv
src/dcache_lce.sv
bench/tb_dcache_lce.sv

// File: Bender.yml
package:
  name: dcache_lce

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/lce_pkg.sv
      - src/lce_credits.sv
      - dcache_lce/lce_req.sv
      - dcache_lce/lce_cmd.sv
      - src/dcache_lce.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/tb_dcache_lce.sv

// File: bench/tb_dcache_lce.sv
`timescale 1ns/1ns

`include "lce_consts.svh"

module tb_dcache_lce
  import lce_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int TIMEOUT    = 200;
  localparam logic [`LCE_ID_W-1:0] LCE_ID = 2'd2;

  // miss kinds as the cache raises them
  localparam int MISS_LOAD     = 0;
  localparam int MISS_STORE    = 1;
  localparam int MISS_LR       = 2;
  localparam int MISS_UC_LOAD  = 3;
  localparam int MISS_UC_STORE = 4;

  logic                      clk_i;
  logic                      reset_i;
  logic [`LCE_ID_W-1:0]      lce_id_i;
  logic                      load_miss_i;
  logic                      store_miss_i;
  logic                      lr_miss_i;
  logic [`LCE_PADDR_W-1:0]   miss_addr_i;
  logic [`LCE_WAY_ID_W-1:0]  lru_way_i;
  logic [`LCE_WAYS-1:0]      dirty_i;
  logic                      uncached_load_req_i;
  logic                      uncached_store_req_i;
  logic [`LCE_DWORD_W-1:0]   store_data_i;
  logic [1:0]                size_op_i;
  logic                      cache_miss_o;
  logic [`LCE_PADDR_W-1:0]   miss_addr_o;
  lce_cmd_s                  cmd_i;
  logic                      cmd_v_i;
  lce_req_s                  lce_req_o;
  logic                      lce_req_v_o;
  logic                      lce_req_ready_i;
  lce_resp_s                 lce_resp_o;
  logic                      lce_resp_v_o;
  logic                      lce_resp_yumi_i;
  logic                      tag_w_v_o;
  tag_write_s                tag_w_o;
  logic                      fill_v_o;
  logic [`LCE_DWORD_W-1:0]   fill_data_o;
  logic [`LCE_WAY_ID_W-1:0]  fill_way_o;
  logic                      credit_return_i;

  integer    seed;
  // 0 steady, 1 random, 2 ready held low
  int        ready_mode;
  int        req_cnt;
  int        resp_cnt;
  int        err_cnt;
  int        test_err_base;
  int        tests_run;
  int        tests_failed;
  lce_req_s  exp_req_q[$];
  lce_resp_s exp_resp_q[$];
  lce_req_s  held_req;
  logic      held_v;

  dcache_lce u_dcache_lce (.*);

  always #(CLK_PERIOD/2) clk_i = ~clk_i;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    err_cnt++;
  endtask

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    assert (got === exp) else begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  // expected request built from the miss as the cache presents it
  function automatic lce_req_s expected_req(input int kind,
                                            input logic [`LCE_PADDR_W-1:0] addr,
                                            input logic [`LCE_WAY_ID_W-1:0] lru,
                                            input logic [`LCE_WAYS-1:0] dirty,
                                            input logic [1:0] size,
                                            input logic [`LCE_DWORD_W-1:0] data);
    lce_req_s r;
    r = '0;
    r.dst_id = addr[`LCE_BLOCK_OFFSET_W];
    r.src_id = LCE_ID;
    r.addr   = addr;
    case (kind)
      MISS_LOAD:           r.msg_type = e_req_rd;
      MISS_STORE, MISS_LR: r.msg_type = e_req_wr;
      MISS_UC_LOAD:        r.msg_type = e_req_uc_rd;
      default:             r.msg_type = e_req_uc_wr;
    endcase
    if (kind <= MISS_LR) begin
      r.msg.cached.lru_way_id = lru;
      r.msg.cached.lru_dirty  = dirty[lru];
    end else begin
      r.msg.uc.size = size;
      if (kind == MISS_UC_STORE) begin
        r.msg.uc.data = data;
      end
    end
    return r;
  endfunction

  function automatic lce_resp_s expected_ack(input logic [`LCE_PADDR_W-1:0] addr);
    lce_resp_s r;
    r.dst_id   = addr[`LCE_BLOCK_OFFSET_W];
    r.src_id   = LCE_ID;
    r.msg_type = e_resp_coh_ack;
    r.addr     = addr;
    return r;
  endfunction

  // CCE side of the request and response channels
  always @(negedge clk_i) begin
    if (reset_i) begin
      lce_req_ready_i <= 1'b0;
      lce_resp_yumi_i <= 1'b0;
    end else if (ready_mode == 1) begin
      lce_req_ready_i <= (($random(seed) & 3) == 0);
      lce_resp_yumi_i <= lce_resp_v_o && (($random(seed) & 1) == 1);
    end else begin
      lce_req_ready_i <= (ready_mode == 0);
      lce_resp_yumi_i <= lce_resp_v_o;
    end
  end

  // every transfer on both channels against the expected queues
  always @(posedge clk_i) begin
    if (reset_i) begin
      held_v = 1'b0;
    end else begin
      if (held_v) begin
        assert (lce_req_v_o) else report_failure("request valid dropped before ready");
        check_value("lce_req_o", lce_req_o, held_req);
      end
      if (lce_req_v_o && lce_req_ready_i) begin
        req_cnt++;
        assert (exp_req_q.size() > 0) else report_failure("request sent with none expected");
        if (exp_req_q.size() > 0) begin
          check_value("lce_req_o", lce_req_o, exp_req_q.pop_front());
        end
      end
      if (lce_resp_v_o && lce_resp_yumi_i) begin
        resp_cnt++;
        assert (exp_resp_q.size() > 0) else report_failure("response sent with none expected");
        if (exp_resp_q.size() > 0) begin
          check_value("lce_resp_o", lce_resp_o, exp_resp_q.pop_front());
        end
      end
      held_v   = lce_req_v_o && !lce_req_ready_i;
      held_req = lce_req_o;
    end
  end

  task automatic start_miss(input int kind, input logic [`LCE_PADDR_W-1:0] addr,
                            input logic [`LCE_WAY_ID_W-1:0] lru,
                            input logic [`LCE_WAYS-1:0] dirty, input logic [1:0] size);
    exp_req_q.push_back(expected_req(kind, addr, lru, dirty, size, '0));
    miss_addr_i         = addr;
    lru_way_i           = lru;
    dirty_i             = dirty;
    size_op_i           = size;
    load_miss_i         = (kind == MISS_LOAD);
    store_miss_i        = (kind == MISS_STORE);
    lr_miss_i           = (kind == MISS_LR);
    uncached_load_req_i = (kind == MISS_UC_LOAD);
    #(CLK_PERIOD/4);
    check_value("cache_miss_o", cache_miss_o, 1'b1);
    @(negedge clk_i);
    load_miss_i         = 1'b0;
    store_miss_i        = 1'b0;
    lr_miss_i           = 1'b0;
    uncached_load_req_i = 1'b0;
  endtask

  task automatic wait_req(input int target);
    int i;
    i = 0;
    while (req_cnt < target && i < TIMEOUT) begin
      @(negedge clk_i);
      i++;
    end
    assert (req_cnt >= target) else report_failure("timed out waiting for a request transfer");
  endtask

  task automatic wait_resp(input int target);
    int i;
    i = 0;
    while (resp_cnt < target && i < TIMEOUT) begin
      @(negedge clk_i);
      i++;
    end
    assert (resp_cnt >= target) else report_failure("timed out waiting for the coh_ack");
  endtask

  task automatic wait_miss_clear();
    int i;
    i = 0;
    while (cache_miss_o && i < TIMEOUT) begin
      @(negedge clk_i);
      i++;
    end
    assert (!cache_miss_o) else report_failure("timed out waiting for the miss to clear");
  endtask

  task automatic return_credits(input int n);
    credit_return_i = 1'b1;
    repeat (n) @(negedge clk_i);
    credit_return_i = 1'b0;
  endtask

  // command in this cycle, strobes checked in the next
  task automatic send_cmd(input lce_cmd_type_e kind, input logic [`LCE_WAY_ID_W-1:0] way,
                          input logic [`LCE_PADDR_W-1:0] addr,
                          input logic [`LCE_DWORD_W-1:0] data);
    tag_write_s exp_tag;
    logic       exp_tag_v;
    logic       exp_fill_v;
    exp_tag.way = way;
    exp_tag.tag = `LCE_TAG_W'(addr >> (`LCE_INDEX_W + `LCE_BLOCK_OFFSET_W));
    exp_tag_v   = (kind == e_cmd_set_tag) || (kind == e_cmd_set_tag_wakeup);
    exp_fill_v  = (kind == e_cmd_data);
    cmd_i.msg_type = kind;
    cmd_i.way_id   = way;
    cmd_i.addr     = addr;
    cmd_i.data     = data;
    cmd_v_i        = 1'b1;
    @(negedge clk_i);
    cmd_v_i = 1'b0;
    check_value("tag_w_v_o", tag_w_v_o, exp_tag_v);
    check_value("fill_v_o", fill_v_o, exp_fill_v);
    if (exp_tag_v) begin
      check_value("tag_w_o", tag_w_o, exp_tag);
    end
    if (exp_fill_v) begin
      check_value("fill_way_o", fill_way_o, way);
      check_value("fill_data_o", fill_data_o, data);
    end
  endtask

  task automatic expect_ack_done(input int target);
    wait_resp(target);
    check_value("cache_miss_o", cache_miss_o, 1'b0);
    repeat (4) @(negedge clk_i);
    check_value("coh_ack count", resp_cnt, target);
  endtask

  task automatic send_uc_store(input logic [`LCE_PADDR_W-1:0] addr,
                               input logic [`LCE_DWORD_W-1:0] data,
                               input logic [1:0] size, input int stall_cycles);
    int target;
    target = req_cnt + 1;
    if (stall_cycles == 0) begin
      exp_req_q.push_back(expected_req(MISS_UC_STORE, addr, '0, '0, size, data));
    end
    miss_addr_i          = addr;
    store_data_i         = data;
    size_op_i            = size;
    uncached_store_req_i = 1'b1;
    if (stall_cycles > 0) begin
      repeat (stall_cycles) begin
        @(negedge clk_i);
        check_value("cache_miss_o", cache_miss_o, 1'b1);
      end
      check_value("request count", req_cnt, target - 1);
      exp_req_q.push_back(expected_req(MISS_UC_STORE, addr, '0, '0, size, data));
      return_credits(1);
    end
    wait_req(target);
    uncached_store_req_i = 1'b0;
  endtask

  task automatic finish_test(input string name);
    int errs;
    assert (exp_req_q.size() == 0 && exp_resp_q.size() == 0)
      else report_failure("an expected transfer never happened");
    exp_req_q.delete();
    exp_resp_q.delete();
    errs = err_cnt - test_err_base;
    tests_run++;
    if (errs == 0) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name, errs);
    end
    test_err_base = err_cnt;
  endtask

  initial begin
    int target;
    int i;
    clk_i                = 1'b0;
    reset_i              = 1'b1;
    lce_id_i             = LCE_ID;
    load_miss_i          = 1'b0;
    store_miss_i         = 1'b0;
    lr_miss_i            = 1'b0;
    miss_addr_i          = '0;
    lru_way_i            = '0;
    dirty_i              = '0;
    uncached_load_req_i  = 1'b0;
    uncached_store_req_i = 1'b0;
    store_data_i         = '0;
    size_op_i            = '0;
    cmd_i                = '0;
    cmd_v_i              = 1'b0;
    lce_req_ready_i      = 1'b0;
    lce_resp_yumi_i      = 1'b0;
    credit_return_i      = 1'b0;
    seed                 = 32'hcb3e_1f64;
    ready_mode           = 0;
    req_cnt              = 0;
    resp_cnt             = 0;
    err_cnt              = 0;
    test_err_base        = 0;
    tests_run            = 0;
    tests_failed         = 0;
    repeat (8) @(negedge clk_i);
    reset_i = 1'b0;
    check_value("cache_miss_o", cache_miss_o, 1'b0);
    check_value("lce_req_v_o", lce_req_v_o, 1'b0);
    check_value("lce_resp_v_o", lce_resp_v_o, 1'b0);
    check_value("tag_w_v_o", tag_w_v_o, 1'b0);
    check_value("fill_v_o", fill_v_o, 1'b0);
    finish_test("reset");

    // load miss on a dirty way with data before set_tag
    target = req_cnt + 1;
    start_miss(MISS_LOAD, 22'h1b3c0, 3'd5, 8'b0010_0000, 2'd3);
    wait_req(target);
    check_value("miss_addr_o", miss_addr_o, 22'h1b3c0);
    return_credits(1);
    exp_resp_q.push_back(expected_ack(22'h1b3c0));
    target = resp_cnt + 1;
    send_cmd(e_cmd_data, 3'd5, 22'h1b3c0, 64'h0123_4567_89ab_cdef);
    send_cmd(e_cmd_set_tag, 3'd5, 22'h1b3c0, '0);
    expect_ack_done(target);
    finish_test("load miss");

    // both go out as writes and wake on set_tag_wakeup
    for (i = 0; i < 2; i++) begin
      target = req_cnt + 1;
      start_miss(i == 0 ? MISS_STORE : MISS_LR, i == 0 ? 22'h0a480 : 22'h3f0c0,
                 3'd2 + i[2:0], i == 0 ? 8'h00 : 8'hff, 2'd3);
      wait_req(target);
      return_credits(1);
      exp_resp_q.push_back(expected_ack(i == 0 ? 22'h0a480 : 22'h3f0c0));
      target = resp_cnt + 1;
      send_cmd(e_cmd_set_tag_wakeup, 3'd2 + i[2:0], i == 0 ? 22'h0a480 : 22'h3f0c0, '0);
      expect_ack_done(target);
    end
    finish_test("store and lr miss");

    // lru inputs wander while the request waits for ready
    ready_mode = 2;
    @(negedge clk_i);
    target = req_cnt + 1;
    start_miss(MISS_LOAD, 22'h2a5c0, 3'd6, 8'b0100_0000, 2'd0);
    for (i = 0; i < TIMEOUT && req_cnt < target; i++) begin
      @(negedge clk_i);
      if (i == 3) begin
        ready_mode = 1;
      end
      lru_way_i = lru_way_i + 3'd3;
      dirty_i   = ~dirty_i;
    end
    assert (req_cnt >= target) else report_failure("timed out waiting for the held request");
    return_credits(1);
    repeat (4) @(negedge clk_i);
    check_value("request count", req_cnt, target);
    exp_resp_q.push_back(expected_ack(22'h2a5c0));
    target = resp_cnt + 1;
    send_cmd(e_cmd_set_tag_wakeup, 3'd6, 22'h2a5c0, '0);
    expect_ack_done(target);
    finish_test("back-pressure");

    // uc_data ends the miss without an ack
    target = req_cnt + 1;
    start_miss(MISS_UC_LOAD, 22'h05d48, 3'd0, 8'h00, 2'd2);
    wait_req(target);
    return_credits(1);
    target = resp_cnt;
    send_cmd(e_cmd_uc_data, 3'd0, 22'h05d48, 64'hfeed_0000_0000_0042);
    wait_miss_clear();
    repeat (4) @(negedge clk_i);
    check_value("coh_ack count", resp_cnt, target);
    ready_mode = 0;
    finish_test("uncached load");

    // fill every credit, then one more store stalls until a return
    for (i = 0; i < `LCE_CREDITS; i++) begin
      send_uc_store(22'h10000 + i * 22'h40, {32'hc0de_0000, i}, i[1:0], 0);
    end
    send_uc_store(22'h12340, 64'h5a5a_a5a5_0f0f_f0f0, 2'd3, 5);
    return_credits(`LCE_CREDITS);
    finish_test("credits and uncached stores");

    // two tag writes, then the fill that completes the miss
    target = req_cnt + 1;
    start_miss(MISS_LOAD, 22'h33a40, 3'd1, 8'h00, 2'd3);
    wait_req(target);
    return_credits(1);
    exp_resp_q.push_back(expected_ack(22'h33a40));
    target = resp_cnt + 1;
    send_cmd(e_cmd_set_tag, 3'd3, 22'h2f000, '0);
    send_cmd(e_cmd_set_tag, 3'd6, 22'h15fc0, '0);
    send_cmd(e_cmd_data, 3'd1, 22'h33a40, 64'h8bad_f00d_cafe_0101);
    expect_ack_done(target);
    finish_test("cache write strobes");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: src/dcache_lce.sv
`timescale 1ns/1ns

`include "lce_consts.svh"

module dcache_lce
  import lce_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic [`LCE_ID_W-1:0]        lce_id_i,

  input  logic                        load_miss_i,
  input  logic                        store_miss_i,
  input  logic                        lr_miss_i,
  input  logic [`LCE_PADDR_W-1:0]     miss_addr_i,
  input  logic [`LCE_WAY_ID_W-1:0]    lru_way_i,
  input  logic [`LCE_WAYS-1:0]        dirty_i,
  input  logic                        uncached_load_req_i,
  input  logic                        uncached_store_req_i,
  input  logic [`LCE_DWORD_W-1:0]     store_data_i,
  input  logic [1:0]                  size_op_i,

  output logic                        cache_miss_o,
  output logic [`LCE_PADDR_W-1:0]     miss_addr_o,

  input  lce_cmd_s                    cmd_i,
  input  logic                        cmd_v_i,

  output lce_req_s                    lce_req_o,
  output logic                        lce_req_v_o,
  input  logic                        lce_req_ready_i,

  output lce_resp_s                   lce_resp_o,
  output logic                        lce_resp_v_o,
  input  logic                        lce_resp_yumi_i,

  output logic                        tag_w_v_o,
  output tag_write_s                  tag_w_o,
  output logic                        fill_v_o,
  output logic [`LCE_DWORD_W-1:0]     fill_data_o,
  output logic [`LCE_WAY_ID_W-1:0]    fill_way_o,

  input  logic                        credit_return_i
);

  // command handler to request handler
  logic set_tag_received;
  logic set_tag_wakeup_received;
  logic data_received;
  logic uc_data_received;

  logic req_sent;
  logic credits_full;

  lce_req u_lce_req (
    .clk_i                     (clk_i),
    .reset_i                   (reset_i),
    .lce_id_i                  (lce_id_i),
    .load_miss_i               (load_miss_i),
    .store_miss_i              (store_miss_i),
    .lr_miss_i                 (lr_miss_i),
    .miss_addr_i               (miss_addr_i),
    .lru_way_i                 (lru_way_i),
    .dirty_i                   (dirty_i),
    .uncached_load_req_i       (uncached_load_req_i),
    .uncached_store_req_i      (uncached_store_req_i),
    .store_data_i              (store_data_i),
    .size_op_i                 (size_op_i),
    .set_tag_received_i        (set_tag_received),
    .set_tag_wakeup_received_i (set_tag_wakeup_received),
    .data_received_i           (data_received),
    .uc_data_received_i        (uc_data_received),
    .cache_miss_o              (cache_miss_o),
    .miss_addr_o               (miss_addr_o),
    .lce_req_o                 (lce_req_o),
    .lce_req_v_o               (lce_req_v_o),
    .lce_req_ready_i           (lce_req_ready_i),
    .lce_resp_o                (lce_resp_o),
    .lce_resp_v_o              (lce_resp_v_o),
    .lce_resp_yumi_i           (lce_resp_yumi_i),
    .credits_full_i            (credits_full),
    .req_sent_o                (req_sent)
  );

  lce_cmd u_lce_cmd (
    .clk_i                     (clk_i),
    .reset_i                   (reset_i),
    .cmd_i                     (cmd_i),
    .cmd_v_i                   (cmd_v_i),
    .set_tag_received_o        (set_tag_received),
    .set_tag_wakeup_received_o (set_tag_wakeup_received),
    .data_received_o           (data_received),
    .uc_data_received_o        (uc_data_received),
    .tag_w_v_o                 (tag_w_v_o),
    .tag_w_o                   (tag_w_o),
    .fill_v_o                  (fill_v_o),
    .fill_data_o               (fill_data_o),
    .fill_way_o                (fill_way_o)
  );

  lce_credits u_lce_credits (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .req_sent_i      (req_sent),
    .credit_return_i (credit_return_i),
    .credits_full_o  (credits_full)
  );

endmodule

// File: dcache_lce/lce_cmd.sv
`timescale 1ns/1ns

`include "lce_consts.svh"

module lce_cmd
  import lce_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        reset_i,

  input  lce_cmd_s                    cmd_i,
  input  logic                        cmd_v_i,

  output logic                        set_tag_received_o,
  output logic                        set_tag_wakeup_received_o,
  output logic                        data_received_o,
  output logic                        uc_data_received_o,

  output logic                        tag_w_v_o,
  output tag_write_s                  tag_w_o,

  output logic                        fill_v_o,
  output logic [`LCE_DWORD_W-1:0]     fill_data_o,
  output logic [`LCE_WAY_ID_W-1:0]    fill_way_o
);

  lce_cmd_s cmd_r;
  logic     cmd_v_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cmd_v_r <= 1'b0;
    end else begin
      cmd_v_r <= cmd_v_i;
    end
  end

  // last valid command
  always_ff @(posedge clk_i) begin
    if (cmd_v_i) begin
      cmd_r <= cmd_i;
    end
  end

  // wake-up strobes for the request handler
  assign set_tag_received_o        = cmd_v_r & (cmd_r.msg_type == e_cmd_set_tag);
  assign set_tag_wakeup_received_o = cmd_v_r & (cmd_r.msg_type == e_cmd_set_tag_wakeup);
  assign data_received_o           = cmd_v_r & (cmd_r.msg_type == e_cmd_data);
  assign uc_data_received_o        = cmd_v_r & (cmd_r.msg_type == e_cmd_uc_data);

  // both set_tag flavours update the tag array
  assign tag_w_v_o   = set_tag_received_o | set_tag_wakeup_received_o;
  assign tag_w_o.way = cmd_r.way_id;
  assign tag_w_o.tag = cmd_r.addr[`LCE_PADDR_W-1 -: `LCE_TAG_W];

  // data word goes into the named way
  assign fill_v_o    = data_received_o;
  assign fill_data_o = cmd_r.data;
  assign fill_way_o  = cmd_r.way_id;

  a_cmd_type_known: assert property (@(posedge clk_i) disable iff (reset_i)
    cmd_v_i |-> !$isunknown(cmd_i.msg_type));

endmodule

// File: dcache_lce/lce_req.sv
`timescale 1ns/1ns

`include "lce_consts.svh"

module lce_req
  import lce_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic [`LCE_ID_W-1:0]        lce_id_i,

  input  logic                        load_miss_i,
  input  logic                        store_miss_i,
  input  logic                        lr_miss_i,
  input  logic [`LCE_PADDR_W-1:0]     miss_addr_i,
  input  logic [`LCE_WAY_ID_W-1:0]    lru_way_i,
  input  logic [`LCE_WAYS-1:0]        dirty_i,

  input  logic                        uncached_load_req_i,
  input  logic                        uncached_store_req_i,
  input  logic [`LCE_DWORD_W-1:0]     store_data_i,
  input  logic [1:0]                  size_op_i,

  input  logic                        set_tag_received_i,
  input  logic                        set_tag_wakeup_received_i,
  input  logic                        data_received_i,
  input  logic                        uc_data_received_i,

  output logic                        cache_miss_o,
  output logic [`LCE_PADDR_W-1:0]     miss_addr_o,

  output lce_req_s                    lce_req_o,
  output logic                        lce_req_v_o,
  input  logic                        lce_req_ready_i,

  output lce_resp_s                   lce_resp_o,
  output logic                        lce_resp_v_o,
  input  logic                        lce_resp_yumi_i,

  input  logic                        credits_full_i,
  output logic                        req_sent_o
);

  typedef enum logic [2:0] {
    e_ready,
    e_send_cached_req,
    e_send_uc_load_req,
    e_sleep,
    e_send_coh_ack
  } req_state_e;

  req_state_e state_r, state_n;

  // control flags
  logic lru_flopped_r, lru_flopped_n;
  logic set_tag_seen_r, set_tag_seen_n;
  logic data_seen_r, data_seen_n;

  // miss payload
  logic                      load_not_store_r, load_not_store_n;
  logic [`LCE_PADDR_W-1:0]   miss_addr_r, miss_addr_n;
  logic [`LCE_WAY_ID_W-1:0]  lru_way_r, lru_way_n;
  logic                      lru_dirty_r, lru_dirty_n;
  logic [1:0]                size_op_r, size_op_n;

  logic set_tag_seen;
  logic data_seen;
  logic miss_start;

  assign set_tag_seen = set_tag_seen_r | set_tag_received_i;
  assign data_seen    = data_seen_r | data_received_i;
  assign miss_start   = load_miss_i | store_miss_i | lr_miss_i | uncached_load_req_i;
  assign miss_addr_o  = miss_addr_r;
  assign req_sent_o   = lce_req_v_o & lce_req_ready_i;

  always_comb begin
    state_n          = state_r;
    lru_flopped_n    = lru_flopped_r;
    set_tag_seen_n   = set_tag_seen_r;
    data_seen_n      = data_seen_r;
    load_not_store_n = load_not_store_r;
    miss_addr_n      = miss_addr_r;
    lru_way_n        = lru_way_r;
    lru_dirty_n      = lru_dirty_r;
    size_op_n        = size_op_r;

    cache_miss_o = 1'b0;
    lce_req_v_o  = 1'b0;
    lce_resp_v_o = 1'b0;

    lce_req_o.dst_id   = miss_addr_r[`LCE_BLOCK_OFFSET_W +: `LCE_CCE_ID_W];
    lce_req_o.src_id   = lce_id_i;
    lce_req_o.msg_type = e_req_rd;
    lce_req_o.addr     = miss_addr_r;
    lce_req_o.msg      = '0;

    lce_resp_o.dst_id   = miss_addr_r[`LCE_BLOCK_OFFSET_W +: `LCE_CCE_ID_W];
    lce_resp_o.src_id   = lce_id_i;
    lce_resp_o.msg_type = e_resp_coh_ack;
    lce_resp_o.addr     = miss_addr_r;

    case (state_r)
      e_ready: begin
        if (miss_start) begin
          cache_miss_o   = 1'b1;
          miss_addr_n    = miss_addr_i;
          size_op_n      = size_op_i;
          lru_flopped_n  = 1'b0;
          set_tag_seen_n = 1'b0;
          data_seen_n    = 1'b0;
          // lr goes out as a write to get the block exclusive
          load_not_store_n = load_miss_i;
          if (load_miss_i | store_miss_i | lr_miss_i) begin
            state_n = e_send_cached_req;
          end else begin
            state_n = e_send_uc_load_req;
          end
        end else if (uncached_store_req_i) begin
          // outside holds the strobe until the store goes out
          lce_req_v_o  = lce_req_ready_i & ~credits_full_i;
          cache_miss_o = ~lce_req_ready_i | credits_full_i;
          lce_req_o.dst_id      = miss_addr_i[`LCE_BLOCK_OFFSET_W +: `LCE_CCE_ID_W];
          lce_req_o.msg_type    = e_req_uc_wr;
          lce_req_o.addr        = miss_addr_i;
          lce_req_o.msg.uc.size = size_op_i;
          lce_req_o.msg.uc.data = store_data_i;
        end
      end

      e_send_cached_req: begin
        cache_miss_o  = 1'b1;
        lce_req_v_o   = 1'b1;
        // sample lru info once, then hold it under back-pressure
        lru_flopped_n = 1'b1;
        lru_way_n     = lru_flopped_r ? lru_way_r : lru_way_i;
        lru_dirty_n   = lru_flopped_r ? lru_dirty_r : dirty_i[lru_way_i];
        lce_req_o.msg_type                 = load_not_store_r ? e_req_rd : e_req_wr;
        lce_req_o.msg.cached.lru_dirty     = lru_dirty_n;
        lce_req_o.msg.cached.lru_way_id    = lru_way_n;
        lce_req_o.msg.cached.non_exclusive = 1'b0;
        if (lce_req_ready_i) begin
          state_n = e_sleep;
        end
      end

      e_send_uc_load_req: begin
        cache_miss_o          = 1'b1;
        lce_req_v_o           = 1'b1;
        lce_req_o.msg_type    = e_req_uc_rd;
        lce_req_o.msg.uc.size = size_op_r;
        if (lce_req_ready_i) begin
          state_n = e_sleep;
        end
      end

      e_sleep: begin
        cache_miss_o   = 1'b1;
        set_tag_seen_n = set_tag_seen;
        data_seen_n    = data_seen;
        if (set_tag_wakeup_received_i) begin
          state_n = e_send_coh_ack;
        end else if (uc_data_received_i) begin
          state_n = e_ready;
        end else if (set_tag_seen & data_seen) begin
          state_n = e_send_coh_ack;
        end
      end

      e_send_coh_ack: begin
        cache_miss_o = 1'b1;
        lce_resp_v_o = 1'b1;
        if (lce_resp_yumi_i) begin
          state_n = e_ready;
        end
      end

      default: begin
        state_n = e_ready;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r        <= e_ready;
      lru_flopped_r  <= 1'b0;
      set_tag_seen_r <= 1'b0;
      data_seen_r    <= 1'b0;
    end else begin
      state_r        <= state_n;
      lru_flopped_r  <= lru_flopped_n;
      set_tag_seen_r <= set_tag_seen_n;
      data_seen_r    <= data_seen_n;
    end
  end

  always_ff @(posedge clk_i) begin
    load_not_store_r <= load_not_store_n;
    miss_addr_r      <= miss_addr_n;
    lru_way_r        <= lru_way_n;
    lru_dirty_r      <= lru_dirty_n;
    size_op_r        <= size_op_n;
  end

  // command handler must not wake an idle engine
  a_no_wakeup_in_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    state_r == e_ready |-> !(set_tag_received_i || set_tag_wakeup_received_i
                             || data_received_i || uc_data_received_i));

  a_yumi_with_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    lce_resp_yumi_i |-> lce_resp_v_o);

endmodule

// File: src/lce_credits.sv
`timescale 1ns/1ns

`include "lce_consts.svh"

module lce_credits (
  input  logic clk_i,
  input  logic reset_i,
  input  logic req_sent_i,
  input  logic credit_return_i,
  output logic credits_full_o
);

  localparam int CNT_W = $clog2(`LCE_CREDITS + 1);

  logic [CNT_W-1:0] credits_r;

  // a send and a return in one cycle leave the count as is
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credits_r <= '0;
    end else if (req_sent_i & ~credit_return_i) begin
      credits_r <= credits_r + 1'b1;
    end else if (credit_return_i & ~req_sent_i) begin
      credits_r <= credits_r - 1'b1;
    end
  end

  assign credits_full_o = (credits_r == CNT_W'(`LCE_CREDITS));

  // a send while full would push the count past the limit next cycle
  a_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
    credits_full_o && !credit_return_i |-> !req_sent_i);

  a_no_return_at_zero: assert property (@(posedge clk_i) disable iff (reset_i)
    credit_return_i |-> credits_r != '0);

endmodule

// File: common/lce_pkg.sv
`include "lce_consts.svh"

package lce_pkg;

  typedef enum logic [1:0] {
    e_req_rd    = 2'b00,
    e_req_wr    = 2'b01,
    e_req_uc_rd = 2'b10,
    e_req_uc_wr = 2'b11
  } lce_req_type_e;

  typedef enum logic [1:0] {
    e_cmd_set_tag        = 2'b00,
    e_cmd_set_tag_wakeup = 2'b01,
    e_cmd_data           = 2'b10,
    e_cmd_uc_data        = 2'b11
  } lce_cmd_type_e;

  typedef enum logic [0:0] {
    e_resp_coh_ack = 1'b0
  } lce_resp_type_e;

  // 68-bit cached miss payload
  typedef struct packed {
    logic [62:0]                pad;
    logic                       lru_dirty;
    logic [`LCE_WAY_ID_W-1:0]   lru_way_id;
    logic                       non_exclusive;
  } lce_cached_req_s;

  // uncached payload with 66 bits in use
  typedef struct packed {
    logic [1:0]                 pad;
    logic [1:0]                 size;
    logic [`LCE_DWORD_W-1:0]    data;
  } lce_uc_req_s;

  // decoded by msg_type of the enclosing request
  typedef union packed {
    lce_cached_req_s cached;
    lce_uc_req_s     uc;
  } lce_req_msg_u;

  typedef struct packed {
    logic [`LCE_CCE_ID_W-1:0]   dst_id;
    logic [`LCE_ID_W-1:0]       src_id;
    lce_req_type_e              msg_type;
    logic [`LCE_PADDR_W-1:0]    addr;
    lce_req_msg_u               msg;
  } lce_req_s;

  typedef struct packed {
    logic [`LCE_CCE_ID_W-1:0]   dst_id;
    logic [`LCE_ID_W-1:0]       src_id;
    lce_resp_type_e             msg_type;
    logic [`LCE_PADDR_W-1:0]    addr;
  } lce_resp_s;

  typedef struct packed {
    lce_cmd_type_e              msg_type;
    logic [`LCE_WAY_ID_W-1:0]   way_id;
    logic [`LCE_PADDR_W-1:0]    addr;
    logic [`LCE_DWORD_W-1:0]    data;
  } lce_cmd_s;

  typedef struct packed {
    logic [`LCE_WAY_ID_W-1:0]   way;
    logic [`LCE_TAG_W-1:0]      tag;
  } tag_write_s;

endpackage

// File: common/lce_consts.svh
`ifndef LCE_CONSTS_SVH
`define LCE_CONSTS_SVH

// physical address and data word
`define LCE_PADDR_W 22
`define LCE_DWORD_W 64

// cache geometry
`define LCE_WAYS 8
`define LCE_BLOCK_OFFSET_W 6
`define LCE_INDEX_W 6
`define LCE_WAY_ID_W $clog2(`LCE_WAYS)
`define LCE_TAG_W (`LCE_PADDR_W - `LCE_INDEX_W - `LCE_BLOCK_OFFSET_W)

// coherence system
`define LCE_NUM_CCE 2
`define LCE_CCE_ID_W $clog2(`LCE_NUM_CCE)
`define LCE_ID_W 2

// outstanding network messages
`define LCE_CREDITS 4

`endif
